// File: files.f
+incdir+include
hdl/exec_pkg.sv
hdl/exec_issue_if.sv
hdl/issue_queue.sv
hdl/inst_decoder.sv
hdl/exec_alu.sv
hdl/execute_stage.sv
hdl/exec_cluster.sv
tests/tb_exec_cluster.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_exec_cluster
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps

SRCS := $(wildcard hdl/*.sv include/*.svh tests/*.sv)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q '\*\* PASS \*\*' $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_exec_cluster.sv
`include "rv32_opcodes.svh"

module tb_exec_cluster;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_NS = 10;

	typedef struct packed {
		logic [exec_pkg::TAG_W-1:0] tag;
		logic [4:0] rd;
		logic rd_write;
		logic chk_value; // Value is defined for this item.
		logic [31:0] value;
		logic branch;
		logic [31:0] pc_next;
		logic mem_read;
		logic mem_write;
		logic [2:0] width;
		logic sgn;
		logic [31:0] addr;
		logic error;
	} expect_t;

	logic i_clock;
	logic i_reset;
	logic i_issue_valid;
	logic [exec_pkg::TAG_W-1:0] i_tag;
	logic [31:0] i_pc;
	logic [31:0] i_instruction;
	logic [31:0] i_rs1;
	logic [31:0] i_rs2;
	logic o_issue_credit;
	logic o_result_valid;
	logic [exec_pkg::TAG_W-1:0] o_tag;
	logic [4:0] o_rd_index;
	logic o_rd_write;
	logic [31:0] o_rd_value;
	logic o_branch;
	logic [31:0] o_pc_next;
	logic o_mem_read;
	logic o_mem_write;
	exec_pkg::mem_width_t o_mem_width;
	logic o_mem_signed;
	logic [31:0] o_mem_address;
	logic o_error;
	logic i_result_credit;

	expect_t exp_q[$];
	expect_t head;
	int errors;
	int results;
	int sent;
	int up_avail; // Upstream credits held.
	int out_avail; // Downstream credits held by the cluster.
	int owed; // Results consumed, credit not yet returned.
	logic hold;
	logic lat_probe;
	logic [1:0] lat_pipe;
	logic [exec_pkg::TAG_W-1:0] next_tag;

	exec_cluster u_exec_cluster (.*);

	initial begin
		i_clock = 1'b0;
		forever #(CLK_NS / 2) i_clock = ~i_clock;
	end

	////////////////////
	// Reference model.
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			`F3_ADD: return alt ? a - b : a + b;
			`F3_SLL: return a << b[4:0];
			`F3_SLT: return {31'b0, $signed(a) < $signed(b)};
			`F3_SLTU: return {31'b0, a < b};
			`F3_XOR: return a ^ b;
			`F3_SR: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			`F3_OR: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [2:0] access_size(input logic [2:0] f3);
		case (f3[1:0])
			2'b00: return 3'd1;
			2'b01: return 3'd2;
			default: return 3'd4;
		endcase
	endfunction

	function automatic expect_t predict(input logic [31:0] instr, input logic [31:0] pc,
		input logic [31:0] rs1, input logic [31:0] rs2, input logic [exec_pkg::TAG_W-1:0] tag);
		expect_t e;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [2:0] f3;
		logic wr;
		logic taken;
		imm_i = {{20{instr[31]}}, instr[31:20]};
		imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		imm_u = {instr[31:12], 12'b0};
		imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		f3 = instr[14:12];
		wr = 1'b0;
		taken = 1'b0;
		e = '0;
		e.tag = tag;
		e.rd = instr[11:7];
		e.pc_next = pc + 32'd4;
		case (instr[6:0])
			`OP_LUI: begin
				wr = 1'b1;
				e.value = imm_u;
			end
			`OP_AUIPC: begin
				wr = 1'b1;
				e.value = pc + imm_u;
			end
			`OP_JAL: begin
				wr = 1'b1;
				e.value = pc + 32'd4;
				e.branch = 1'b1;
				e.pc_next = pc + imm_j;
			end
			`OP_JALR: begin
				wr = 1'b1;
				e.value = pc + 32'd4;
				e.branch = 1'b1;
				e.pc_next = (rs1 + imm_i) & ~32'd1;
			end
			`OP_BRANCH: begin
				case (f3)
					`F3_BEQ: taken = (rs1 == rs2);
					`F3_BNE: taken = (rs1 != rs2);
					`F3_BLT: taken = ($signed(rs1) < $signed(rs2));
					`F3_BGE: taken = ($signed(rs1) >= $signed(rs2));
					`F3_BLTU: taken = (rs1 < rs2);
					default: taken = (rs1 >= rs2);
				endcase
				e.branch = taken;
				if (taken) begin
					e.pc_next = pc + imm_b;
				end
			end
			`OP_LOAD: begin
				wr = 1'b1;
				e.mem_read = 1'b1;
				e.width = access_size(f3);
				e.sgn = !f3[2];
				e.addr = rs1 + imm_i;
			end
			`OP_STORE: begin
				e.mem_write = 1'b1;
				e.width = access_size(f3);
				e.addr = rs1 + imm_s;
				e.value = rs2; // Store data.
				e.chk_value = 1'b1;
			end
			`OP_IMM: begin
				wr = 1'b1;
				e.value = alu_ref(f3, instr[30] && (f3 == `F3_SR), rs1, imm_i);
			end
			`OP_REG: begin
				wr = 1'b1;
				e.value = alu_ref(f3, instr[30], rs1, rs2);
			end
			default: e.error = 1'b1;
		endcase
		e.rd_write = wr && (e.rd != 5'd0);
		e.chk_value = e.chk_value || (e.rd_write && !e.mem_read);
		return e;
	endfunction

	////////////////////
	// Instruction words use x1 as rs1 and x2 as rs2.
	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd);
		return {f7, 5'd2, 5'd1, f3, rd, `OP_REG};
	endfunction

	function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [2:0] f3,
		input logic [4:0] rd, input logic [6:0] op);
		return {imm, 5'd1, f3, rd, op};
	endfunction

	function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [2:0] f3);
		return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], `OP_STORE};
	endfunction

	function automatic logic [31:0] branch_word(input logic [12:0] imm, input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `OP_BRANCH};
	endfunction

	function automatic logic [31:0] upper_word(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
	endfunction

	function automatic logic [4:0] pick_rd();
		return 5'($urandom_range(31, 1));
	endfunction

	////////////////////
	// Upstream side.
	task automatic send(input logic [31:0] instr, input logic [31:0] rs1, input logic [31:0] rs2);
		logic [31:0] pc;
		pc = $urandom & 32'hffff_fffc;
		while (up_avail == 0) begin
			i_issue_valid = 1'b0;
			@(posedge i_clock);
			#1;
		end
		i_issue_valid = 1'b1;
		i_tag = next_tag;
		i_pc = pc;
		i_instruction = instr;
		i_rs1 = rs1;
		i_rs2 = rs2;
		exp_q.push_back(predict(instr, pc, rs1, rs2, next_tag));
		next_tag++;
		sent++;
		@(posedge i_clock);
		#1;
		i_issue_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || owed != 0) begin
			@(posedge i_clock);
			#1;
		end
		@(posedge i_clock);
		#1;
	endtask

	always @(posedge i_clock) begin
		if (i_reset) begin
			up_avail <= exec_pkg::QUEUE_DEPTH;
			lat_pipe <= 2'b00;
		end
		else begin
			up_avail <= up_avail - int'(i_issue_valid) + int'(o_issue_credit);
			lat_pipe <= {lat_pipe[0], lat_probe};
		end
	end

	////////////////////
	// Downstream credits come back after random gaps.
	always @(posedge i_clock) begin
		if (i_reset) begin
			owed <= 0;
			out_avail <= exec_pkg::OUT_CREDITS;
		end
		else begin
			owed <= owed + int'(o_result_valid) - int'(i_result_credit);
			out_avail <= out_avail - int'(o_result_valid) + int'(i_result_credit);
		end
		#1;
		i_result_credit = !hold && (owed > 0) && ($urandom_range(3, 0) != 0);
	end

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got,
		input logic [exec_pkg::TAG_W-1:0] tag);
		assert (got === exp) else begin
			errors++;
			$display("** Error %s (tag %h): expected %h, got %h", name, tag, exp, got);
		end
	endtask

	always @(posedge i_clock) begin
		if (!i_reset && o_result_valid) begin
			results++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("Result with tag %h arrived with no item outstanding", o_tag);
			end
			else begin
				head = exp_q.pop_front();
				compare("o_tag", 32'(head.tag), 32'(o_tag), head.tag);
				if (head.rd_write) begin
					compare("o_rd_index", 32'(head.rd), 32'(o_rd_index), head.tag);
				end
				compare("o_rd_write", 32'(head.rd_write), 32'(o_rd_write), head.tag);
				if (head.chk_value) begin
					compare("o_rd_value", head.value, o_rd_value, head.tag);
				end
				compare("o_branch", 32'(head.branch), 32'(o_branch), head.tag);
				compare("o_pc_next", head.pc_next, o_pc_next, head.tag);
				compare("o_mem_read", 32'(head.mem_read), 32'(o_mem_read), head.tag);
				compare("o_mem_write", 32'(head.mem_write), 32'(o_mem_write), head.tag);
				compare("o_mem_width", 32'(head.width), 32'(o_mem_width), head.tag);
				compare("o_mem_signed", 32'(head.sgn), 32'(o_mem_signed), head.tag);
				compare("o_mem_address", head.addr, o_mem_address, head.tag);
				compare("o_error", 32'(head.error), 32'(o_error), head.tag);
			end
		end
	end

	////////////////////
	// Protocol and timing.
	a_latency_gap: assert property (@(posedge i_clock) disable iff (i_reset)
		lat_pipe[0] |-> !o_result_valid) else begin
		errors++;
		$display("Result came out one cycle after the accepting edge");
	end

	a_latency: assert property (@(posedge i_clock) disable iff (i_reset)
		lat_pipe[1] |-> o_result_valid) else begin
		errors++;
		$display("No result two cycles after the accepting edge");
	end

	a_out_credit: assert property (@(posedge i_clock) disable iff (i_reset)
		o_result_valid |-> out_avail > 0) else begin
		errors++;
		$display("Result sent while the cluster held no downstream credit");
	end

	a_issue_credit: assert property (@(posedge i_clock) disable iff (i_reset)
		o_issue_credit == o_result_valid) else begin
		errors++;
		$display("Issue credit pulses do not match items leaving the queue");
	end

	a_up_credit_bound: assert property (@(posedge i_clock) disable iff (i_reset)
		up_avail <= exec_pkg::QUEUE_DEPTH) else begin
		errors++;
		$display("Cluster returned more upstream credits than items sent");
	end

	////////////////////
	task automatic alu_tests();
		for (int f = 0; f < 8; f++) begin
			send(r_word(7'd0, 3'(f), pick_rd()), $urandom, $urandom);
			if (f == 0 || f == 5) begin
				send(r_word(`F7_ALT, 3'(f), pick_rd()), $urandom, $urandom);
			end
			if (f == 1 || f == 5) begin
				send(imm_word({7'd0, 5'($urandom)}, 3'(f), pick_rd(), `OP_IMM), $urandom, 0);
			end
			else begin
				send(imm_word(12'($urandom), 3'(f), pick_rd(), `OP_IMM), $urandom, 0);
			end
		end
		send(imm_word({`F7_ALT, 5'($urandom)}, `F3_SR, pick_rd(), `OP_IMM), $urandom, 0);
		send(r_word(7'd0, `F3_ADD, 5'd0), $urandom, $urandom); // x0 stays unwritten.
		send(imm_word(12'($urandom), `F3_ADD, 5'd0, `OP_IMM), $urandom, 0);
		send(upper_word(20'($urandom), pick_rd(), `OP_LUI), $urandom, $urandom);
		send(upper_word(20'($urandom), pick_rd(), `OP_AUIPC), $urandom, $urandom);
	endtask

	task automatic flow_tests();
		logic [31:0] r;
		for (int c = 0; c < 8; c++) begin
			if (c != 2 && c != 3) begin
				r = $urandom & 32'h3fff_ffff;
				send(branch_word(13'($urandom), 3'(c)), r, r + 32'd1);
				send(branch_word(13'($urandom), 3'(c)), r + 32'd1, r);
				send(branch_word(13'($urandom), 3'(c)), r, r);
				send(branch_word(13'($urandom), 3'(c)), r | 32'h8000_0000, r);
			end
		end
		send(jal_word(21'($urandom), pick_rd()), $urandom, $urandom);
		send(imm_word(12'($urandom), 3'd0, pick_rd(), `OP_JALR), $urandom, $urandom);
		send(imm_word(12'($urandom), 3'd0, pick_rd(), `OP_JALR), $urandom, $urandom);
	endtask

	task automatic memory_tests();
		for (int f = 0; f < 6; f++) begin
			if (f != 3) begin
				send(imm_word(12'($urandom), 3'(f), pick_rd(), `OP_LOAD), $urandom, $urandom);
			end
		end
		for (int f = 0; f < 3; f++) begin
			send(store_word(12'($urandom), 3'(f)), $urandom, $urandom);
		end
		send({25'($urandom), 7'b1111111}, $urandom, $urandom);
		send({25'($urandom), 7'b0000000}, $urandom, $urandom);
	endtask

	task automatic latency_test();
		wait_drain();
		lat_probe = 1'b1;
		send(r_word(7'd0, `F3_ADD, pick_rd()), $urandom, $urandom);
		lat_probe = 1'b0;
	endtask

	task automatic stall_test();
		wait_drain();
		hold = 1'b1;
		repeat (exec_pkg::OUT_CREDITS + exec_pkg::QUEUE_DEPTH) begin
			send(r_word(7'd0, 3'($urandom), pick_rd()), $urandom, $urandom);
		end
		repeat (20) @(posedge i_clock);
		#1;
		assert (exp_q.size() == exec_pkg::QUEUE_DEPTH) else begin
			errors++;
			$display("Stall held back %0d items instead of a full queue", exp_q.size());
		end
		hold = 1'b0;
		wait_drain();
	endtask

	initial begin
		while ($time <= 64'(sent * 200 * CLK_NS + 1000)) begin
			@(posedge i_clock);
		end
		$display("Timeout: results stopped arriving after %0d items sent", sent);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		void'($urandom(32'h1c1f));
		i_reset = 1'b1;
		i_issue_valid = 1'b0;
		i_tag = '0;
		i_pc = '0;
		i_instruction = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		i_result_credit = 1'b0;
		hold = 1'b0;
		lat_probe = 1'b0;
		errors = 0;
		results = 0;
		sent = 0;
		next_tag = '0;
		repeat (2) @(posedge i_clock);
		#1;
		i_reset = 1'b0;

		alu_tests();
		flow_tests();
		memory_tests();
		latency_test();
		stall_test();
		repeat (24) begin
			send(r_word(7'd0, 3'($urandom), pick_rd()), $urandom, $urandom); // Back to back.
		end
		wait_drain();

		assert (up_avail == exec_pkg::QUEUE_DEPTH) else begin
			errors++;
			$display("Only %0d upstream credits came back", up_avail);
		end
		assert (results == sent) else begin
			errors++;
			$display("Sent %0d items but saw %0d results", sent, results);
		end
		$display("Results checked: %0d of %0d sent, errors: %0d", results, sent, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end
		else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: hdl/exec_cluster.sv
module exec_cluster (
	input logic i_clock,
	input logic i_reset,

	// Upstream.
	input logic i_issue_valid,
	input logic [exec_pkg::TAG_W-1:0] i_tag,
	input logic [exec_pkg::XLEN-1:0] i_pc,
	input logic [exec_pkg::XLEN-1:0] i_instruction,
	input logic [exec_pkg::XLEN-1:0] i_rs1,
	input logic [exec_pkg::XLEN-1:0] i_rs2,
	output logic o_issue_credit,

	// Downstream.
	output logic o_result_valid,
	output logic [exec_pkg::TAG_W-1:0] o_tag,
	output logic [4:0] o_rd_index,
	output logic o_rd_write,
	output logic [exec_pkg::XLEN-1:0] o_rd_value,
	output logic o_branch,
	output logic [exec_pkg::XLEN-1:0] o_pc_next,
	output logic o_mem_read,
	output logic o_mem_write,
	output exec_pkg::mem_width_t o_mem_width,
	output logic o_mem_signed,
	output logic [exec_pkg::XLEN-1:0] o_mem_address,
	output logic o_error,
	input logic i_result_credit
);

	exec_pkg::issue_t issue_item;

	assign issue_item = '{tag: i_tag, pc: i_pc, instruction: i_instruction, rs1: i_rs1, rs2: i_rs2};

	exec_issue_if u_issue_if ();

	issue_queue u_issue_queue (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_push(i_issue_valid),
		.i_item(issue_item),
		.o_credit(o_issue_credit),
		.q(u_issue_if.queue)
	);

	execute_stage u_execute_stage (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.s(u_issue_if.stage),
		.i_result_credit(i_result_credit),
		.o_result_valid(o_result_valid),
		.o_tag(o_tag),
		.o_rd_index(o_rd_index),
		.o_rd_write(o_rd_write),
		.o_rd_value(o_rd_value),
		.o_branch(o_branch),
		.o_pc_next(o_pc_next),
		.o_mem_read(o_mem_read),
		.o_mem_write(o_mem_write),
		.o_mem_width(o_mem_width),
		.o_mem_signed(o_mem_signed),
		.o_mem_address(o_mem_address),
		.o_error(o_error)
	);

endmodule

// File: hdl/execute_stage.sv
module execute_stage (
	input logic i_clock,
	input logic i_reset,
	exec_issue_if.stage s,
	input logic i_result_credit,

	output logic o_result_valid,
	output logic [exec_pkg::TAG_W-1:0] o_tag,
	output logic [4:0] o_rd_index,
	output logic o_rd_write,
	output logic [exec_pkg::XLEN-1:0] o_rd_value,
	output logic o_branch,
	output logic [exec_pkg::XLEN-1:0] o_pc_next,
	output logic o_mem_read,
	output logic o_mem_write,
	output exec_pkg::mem_width_t o_mem_width,
	output logic o_mem_signed,
	output logic [exec_pkg::XLEN-1:0] o_mem_address,
	output logic o_error
);

	exec_pkg::decode_t dec;
	logic [exec_pkg::XLEN-1:0] alu_op1;
	logic [exec_pkg::XLEN-1:0] alu_op2;
	logic [exec_pkg::XLEN-1:0] alu_result;
	logic [exec_pkg::XLEN-1:0] pc_plus4;
	logic [exec_pkg::XLEN-1:0] pc_target;
	logic [exec_pkg::CREDIT_W-1:0] credits;
	logic take;
	logic cond;
	logic taken;

	inst_decoder u_decoder (
		.i_instruction(s.item.instruction),
		.o_dec(dec)
	);

	always_comb begin
		case (dec.op_a)
			exec_pkg::OPA_PC: alu_op1 = s.item.pc;
			exec_pkg::OPA_ZERO: alu_op1 = '0;
			default: alu_op1 = s.item.rs1;
		endcase
	end

	assign alu_op2 = dec.op_b_imm ? dec.imm : s.item.rs2;

	exec_alu u_alu (
		.i_op(dec.alu_op),
		.i_op1(alu_op1),
		.i_op2(alu_op2),
		.o_result(alu_result)
	);

	////////////////////
	// Control flow.
	assign pc_plus4 = s.item.pc + 32'd4;
	assign pc_target = s.item.pc + dec.imm; // JAL and branches.
	assign cond = (dec.br_cond[2] ? alu_result[0] : (alu_result == '0)) ^ dec.br_cond[0];
	assign taken = dec.branch && cond;

	assign take = s.valid && (credits != '0);
	assign s.take = take;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			credits <= exec_pkg::CREDIT_W'(exec_pkg::OUT_CREDITS);
		end
		else if (take && !i_result_credit) begin
			credits <= credits - 1'b1;
		end
		else if (!take && i_result_credit) begin
			credits <= credits + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_result_valid <= 1'b0;
			o_rd_write <= 1'b0;
			o_branch <= 1'b0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			o_error <= 1'b0;
		end
		else begin
			o_result_valid <= take;
			o_rd_write <= take && dec.rd_write && (dec.rd != 5'd0); // x0 is never written.
			o_branch <= take && (taken || dec.jal || dec.jalr);
			o_mem_read <= take && dec.load;
			o_mem_write <= take && dec.store;
			o_error <= take && dec.illegal;
		end
	end

	always_ff @(posedge i_clock) begin
		if (take) begin
			o_tag <= s.item.tag;
			o_rd_index <= dec.rd;
			o_mem_width <= dec.width;
			o_mem_signed <= dec.is_signed;
			o_mem_address <= (dec.load || dec.store) ? alu_result : '0;

			if (dec.jal || dec.jalr) begin
				o_rd_value <= pc_plus4; // Link address.
			end
			else if (dec.store) begin
				o_rd_value <= s.item.rs2;
			end
			else begin
				o_rd_value <= alu_result;
			end

			if (dec.jalr) begin
				o_pc_next <= {alu_result[exec_pkg::XLEN-1:1], 1'b0};
			end
			else if (dec.jal || taken) begin
				o_pc_next <= pc_target;
			end
			else begin
				o_pc_next <= pc_plus4;
			end
		end
	end

	////////////////////
	a_credit_bound: assert property (@(posedge i_clock) disable iff (i_reset)
		credits <= exec_pkg::CREDIT_W'(exec_pkg::OUT_CREDITS));

	a_mem_onehot: assert property (@(posedge i_clock) disable iff (i_reset)
		!(o_mem_read && o_mem_write));

endmodule

// File: hdl/exec_alu.sv
module exec_alu (
	input exec_pkg::alu_op_t i_op,
	input logic [exec_pkg::XLEN-1:0] i_op1,
	input logic [exec_pkg::XLEN-1:0] i_op2,
	output logic [exec_pkg::XLEN-1:0] o_result
);

	logic [4:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	assign shamt = i_op2[4:0];
	assign lt_signed = $signed(i_op1) < $signed(i_op2);
	assign lt_unsigned = i_op1 < i_op2;

	always_comb begin
		case (i_op)
			exec_pkg::ALU_ADD: o_result = i_op1 + i_op2;
			exec_pkg::ALU_SUB: o_result = i_op1 - i_op2;
			exec_pkg::ALU_SLL: o_result = i_op1 << shamt;
			exec_pkg::ALU_SLT: o_result = {{(exec_pkg::XLEN-1){1'b0}}, lt_signed};
			exec_pkg::ALU_SLTU: o_result = {{(exec_pkg::XLEN-1){1'b0}}, lt_unsigned};
			exec_pkg::ALU_XOR: o_result = i_op1 ^ i_op2;
			exec_pkg::ALU_SRL: o_result = i_op1 >> shamt;
			exec_pkg::ALU_SRA: o_result = $unsigned($signed(i_op1) >>> shamt);
			exec_pkg::ALU_OR: o_result = i_op1 | i_op2;
			exec_pkg::ALU_AND: o_result = i_op1 & i_op2;
			default: o_result = '0;
		endcase
	end

endmodule

// File: hdl/inst_decoder.sv
`include "rv32_opcodes.svh"

module inst_decoder (
	input logic [exec_pkg::XLEN-1:0] i_instruction,
	output exec_pkg::decode_t o_dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt; // funct7 bit 5.

	logic [exec_pkg::XLEN-1:0] imm_i;
	logic [exec_pkg::XLEN-1:0] imm_s;
	logic [exec_pkg::XLEN-1:0] imm_b;
	logic [exec_pkg::XLEN-1:0] imm_u;
	logic [exec_pkg::XLEN-1:0] imm_j;

	function automatic exec_pkg::alu_op_t alu_from_f3(input logic [2:0] f3, input logic sub_sra);
		exec_pkg::alu_op_t op;
		case (f3)
			`F3_ADD: op = sub_sra ? exec_pkg::ALU_SUB : exec_pkg::ALU_ADD;
			`F3_SLL: op = exec_pkg::ALU_SLL;
			`F3_SLT: op = exec_pkg::ALU_SLT;
			`F3_SLTU: op = exec_pkg::ALU_SLTU;
			`F3_XOR: op = exec_pkg::ALU_XOR;
			`F3_SR: op = sub_sra ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL;
			`F3_OR: op = exec_pkg::ALU_OR;
			default: op = exec_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign alt = (i_instruction[31:25] == `F7_ALT);

	////////////////////
	// Immediates.
	assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
	assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
	assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
		i_instruction[30:25], i_instruction[11:8], 1'b0};
	assign imm_u = {i_instruction[31:12], 12'b0};
	assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
		i_instruction[20], i_instruction[30:21], 1'b0};

	always_comb begin
		o_dec = '0; // ADD, rs1 and rs2, no memory access.
		o_dec.rd = i_instruction[11:7];
		o_dec.br_cond = funct3;
		case (opcode)
			`OP_LUI: begin
				o_dec.imm = imm_u;
				o_dec.op_a = exec_pkg::OPA_ZERO;
				o_dec.op_b_imm = 1'b1;
				o_dec.rd_write = 1'b1;
			end
			`OP_AUIPC: begin
				o_dec.imm = imm_u;
				o_dec.op_a = exec_pkg::OPA_PC;
				o_dec.op_b_imm = 1'b1;
				o_dec.rd_write = 1'b1;
			end
			`OP_JAL: begin
				o_dec.imm = imm_j;
				o_dec.jal = 1'b1;
				o_dec.rd_write = 1'b1;
			end
			`OP_JALR: begin
				o_dec.imm = imm_i;
				o_dec.op_b_imm = 1'b1; // Target from rs1 plus imm.
				o_dec.jalr = 1'b1;
				o_dec.rd_write = 1'b1;
			end
			`OP_BRANCH: begin
				o_dec.imm = imm_b;
				o_dec.branch = 1'b1;
				case (funct3[2:1])
					2'b00: o_dec.alu_op = exec_pkg::ALU_SUB; // Equality from zero.
					2'b10: o_dec.alu_op = exec_pkg::ALU_SLT;
					default: o_dec.alu_op = exec_pkg::ALU_SLTU;
				endcase
			end
			`OP_LOAD, `OP_STORE: begin
				o_dec.imm = (opcode == `OP_LOAD) ? imm_i : imm_s;
				o_dec.op_b_imm = 1'b1;
				o_dec.load = (opcode == `OP_LOAD);
				o_dec.store = (opcode == `OP_STORE);
				o_dec.rd_write = (opcode == `OP_LOAD);
				o_dec.is_signed = (opcode == `OP_LOAD) && !funct3[2];
				case (funct3[1:0])
					2'b00: o_dec.width = exec_pkg::MEM_BYTE;
					2'b01: o_dec.width = exec_pkg::MEM_HALF;
					default: o_dec.width = exec_pkg::MEM_WORD;
				endcase
			end
			`OP_IMM: begin
				o_dec.imm = imm_i;
				o_dec.op_b_imm = 1'b1;
				o_dec.alu_op = alu_from_f3(funct3, (funct3 == `F3_SR) && i_instruction[30]);
				o_dec.rd_write = 1'b1;
			end
			`OP_REG: begin
				o_dec.alu_op = alu_from_f3(funct3, alt);
				o_dec.rd_write = 1'b1;
			end
			default: o_dec.illegal = 1'b1;
		endcase
	end

endmodule

// File: hdl/issue_queue.sv
module issue_queue (
	input logic i_clock,
	input logic i_reset,
	input logic i_push,
	input exec_pkg::issue_t i_item,
	output logic o_credit,
	exec_issue_if.queue q
);

	exec_pkg::issue_t mem [exec_pkg::QUEUE_DEPTH];

	logic [exec_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [exec_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [exec_pkg::QUEUE_CNT_W-1:0] count;
	logic pop;

	function automatic logic [exec_pkg::QUEUE_PTR_W-1:0] next_ptr(
		input logic [exec_pkg::QUEUE_PTR_W-1:0] ptr
	);
		return (ptr == exec_pkg::QUEUE_PTR_W'(exec_pkg::QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign pop = q.take;
	assign q.valid = (count != '0);
	assign q.item = mem[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (i_push) begin
			mem[wr_ptr] <= i_item;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_credit <= 1'b0;
		end
		else begin
			o_credit <= pop; // One credit per freed slot.
			if (i_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({i_push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////
	// Upstream must hold a credit, and the stage must see valid.
	a_no_push_full: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_push && count == exec_pkg::QUEUE_CNT_W'(exec_pkg::QUEUE_DEPTH)));

	a_no_take_empty: assert property (@(posedge i_clock) disable iff (i_reset)
		!(q.take && count == '0));

endmodule

// File: hdl/exec_issue_if.sv
interface exec_issue_if;

	logic valid; // Head entry present.
	exec_pkg::issue_t item; // Head entry.
	logic take; // Pop this cycle.

	modport queue (
		output valid,
		output item,
		input take
	);

	modport stage (
		input valid,
		input item,
		output take
	);

endinterface

// File: hdl/exec_pkg.sv
package exec_pkg;

	////////////////////
	// Widths and depths.
	localparam int XLEN = 32;
	localparam int TAG_W = 8;
	localparam int QUEUE_DEPTH = 4; // Also the upstream credits at reset.
	localparam int OUT_CREDITS = 4; // Downstream credits at reset.

	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

	////////////////////
	// Enums.
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_t;

	// Encoded as the access size in bytes.
	typedef enum logic [2:0] {
		MEM_NONE = 3'd0,
		MEM_BYTE = 3'd1,
		MEM_HALF = 3'd2,
		MEM_WORD = 3'd4
	} mem_width_t;

	typedef enum logic [1:0] {
		OPA_RS1,
		OPA_PC,
		OPA_ZERO // LUI only.
	} opa_sel_t;

	////////////////////
	// Structs.
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instruction;
		logic [XLEN-1:0] rs1;
		logic [XLEN-1:0] rs2;
	} issue_t;

	typedef struct packed {
		logic [XLEN-1:0] imm;
		alu_op_t alu_op;
		opa_sel_t op_a; // Operand a source.
		logic op_b_imm; // Operand b is the immediate, else rs2.
		logic [4:0] rd;
		logic rd_write;
		logic load;
		logic store;
		mem_width_t width;
		logic is_signed;
		logic branch;
		logic [2:0] br_cond; // Branch funct3.
		logic jal;
		logic jalr;
		logic illegal;
	} decode_t;

endpackage

// File: include/rv32_opcodes.svh
`ifndef RV32_OPCODES_SVH
`define RV32_OPCODES_SVH

// Major opcodes, bits 6:0.
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

// Branch funct3.
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// Load and store funct3, bit 2 marks unsigned loads.
`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LBU 3'b100
`define F3_LHU 3'b101
`define F3_SB  3'b000
`define F3_SH  3'b001
`define F3_SW  3'b010

// ALU funct3.
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`define F7_ALT 7'b0100000

`endif
